// ==== source/rv_pkg.sv ====
// *************************************************************************
// rv32i core shared types and constants
// *************************************************************************

package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_system = 7'b1110011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [1:0] {
        a_rs1,
        a_pc,
        a_zero      // lui
    } a_sel_t;

    typedef enum logic {
        wb_alu,
        wb_link     // pc + 4 for jal / jalr
    } wb_sel_t;

    // all-zero means a no-op
    typedef struct packed {
        alu_op_t    alu_op;
        a_sel_t     a_sel;
        logic       b_is_imm;
        logic       reg_we;     // already low for rd == x0
        logic       branch;
        logic       jump;
        logic       jalr;
        wb_sel_t    wb_sel;
        logic [2:0] funct3;     // branch condition
        logic       ebreak;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
    } decoded_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      we;
        word_t     wdata;
    } retire_t;

endpackage

// ==== source/pc_unit.sv ====
// *************************************************************************
// program counter and halt flag
// *************************************************************************

module pc_unit #(
    parameter rv_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic          clk,
    input  logic          reset,
    input  rv_pkg::word_t next_pc,
    input  logic          ebreak,
    output rv_pkg::word_t pc,
    output logic          halted
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else if (!halted) begin
            if (ebreak) begin
                halted <= 1'b1;     // pc stays on the ebreak
            end else begin
                pc <= next_pc;
            end
        end
    end

endmodule

// ==== source/inst_decoder.sv ====
// *************************************************************************
// rv32i instruction decoder
// *************************************************************************

module inst_decoder (
    input  rv_pkg::word_t    inst,
    output rv_pkg::decoded_t dec
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_u, imm_j, imm_b;
    logic       f7_ok;
    ctrl_t      ctrl;

    // funct3 plus the alternate bit (inst[30]) gives the alu op
    function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    // 0100000 only legal for sub and sra
    assign f7_ok = (funct7 == 7'b0) ||
                   (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        ctrl    = '0;
        dec.imm = '0;
        case (opcode)
            op_reg: begin
                if (f7_ok) begin
                    ctrl.alu_op = alu_from_funct(funct3, funct7[5]);
                    ctrl.reg_we = 1'b1;
                end
            end
            op_imm: begin
                // only the shifts look at funct7
                if (funct3[1:0] != 2'b01 || f7_ok) begin
                    ctrl.alu_op   = alu_from_funct(funct3, funct3 == 3'b101 && funct7[5]);
                    ctrl.b_is_imm = 1'b1;
                    ctrl.reg_we   = 1'b1;
                end
                dec.imm = imm_i;
            end
            op_lui: begin
                ctrl.a_sel    = a_zero;
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_we   = 1'b1;
                dec.imm       = imm_u;
            end
            op_auipc: begin
                ctrl.a_sel    = a_pc;
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_we   = 1'b1;
                dec.imm       = imm_u;
            end
            op_jal: begin
                ctrl.jump   = 1'b1;
                ctrl.wb_sel = wb_link;
                ctrl.reg_we = 1'b1;
                dec.imm     = imm_j;
            end
            op_jalr: begin
                if (funct3 == 3'b000) begin
                    ctrl.jalr     = 1'b1;
                    ctrl.b_is_imm = 1'b1;    // target = rs1 + imm through the alu
                    ctrl.wb_sel   = wb_link;
                    ctrl.reg_we   = 1'b1;
                end
                dec.imm = imm_i;
            end
            op_branch: begin
                if (funct3[2:1] != 2'b01) begin
                    ctrl.branch = 1'b1;
                    ctrl.funct3 = funct3;
                end
                dec.imm = imm_b;
            end
            op_system: ctrl.ebreak = (inst == 32'h0010_0073);
            default: ;
        endcase
        ctrl.reg_we = ctrl.reg_we && (inst[11:7] != 5'd0);  // x0 never written
        dec.ctrl    = ctrl;
    end

    assign dec.rd  = inst[11:7];
    assign dec.rs1 = inst[19:15];
    assign dec.rs2 = inst[24:20];

endmodule

// ==== source/reg_file.sv ====
// *************************************************************************
// general register file
// *************************************************************************

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);
    import rv_pkg::*;

    word_t regs [1:31];     // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== source/exec_unit.sv ====
// *************************************************************************
// alu, branch compare and next pc
// *************************************************************************

module exec_unit (
    input  rv_pkg::ctrl_t ctrl,
    input  rv_pkg::word_t imm,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t rs2_data,
    output rv_pkg::word_t wb_data,
    output rv_pkg::word_t next_pc
);
    import rv_pkg::*;

    word_t      alu_a, alu_b, alu_y;
    logic [4:0] shamt;
    word_t      pc_plus4, pc_target;
    logic       cond, taken;

    always_comb begin
        case (ctrl.a_sel)
            a_pc:    alu_a = pc;
            a_zero:  alu_a = '0;
            default: alu_a = rs1_data;
        endcase
    end

    assign alu_b = ctrl.b_is_imm ? imm : rs2_data;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            alu_sub:  alu_y = alu_a - alu_b;
            alu_sll:  alu_y = alu_a << shamt;
            alu_slt:  alu_y = {{(xlen-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            alu_sltu: alu_y = {{(xlen-1){1'b0}}, alu_a < alu_b};
            alu_xor:  alu_y = alu_a ^ alu_b;
            alu_srl:  alu_y = alu_a >> shamt;
            alu_sra:  alu_y = $signed(alu_a) >>> shamt;
            alu_or:   alu_y = alu_a | alu_b;
            alu_and:  alu_y = alu_a & alu_b;
            default:  alu_y = alu_a + alu_b;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (ctrl.funct3)
            3'b000:  cond = (rs1_data == rs2_data);
            3'b001:  cond = (rs1_data != rs2_data);
            3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  cond = (rs1_data < rs2_data);
            3'b111:  cond = (rs1_data >= rs2_data);
            default: cond = 1'b0;
        endcase
    end

    assign taken = ctrl.branch && cond;

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;    // branch and jal

    always_comb begin
        if (ctrl.jalr) begin
            next_pc = {alu_y[xlen-1:1], 1'b0};
        end else if (ctrl.jump || taken) begin
            next_pc = pc_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // link value for jal / jalr
    assign wb_data = (ctrl.wb_sel == wb_link) ? pc_plus4 : alu_y;

endmodule

// ==== source/rv_core.sv ====
// *************************************************************************
// rv32i single-cycle core
// *************************************************************************

module rv_core #(
    parameter rv_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::word_t   inst,     // instruction at pc, same cycle
    output rv_pkg::word_t   pc,
    output logic            halted,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    decoded_t dec;
    word_t    rs1_data, rs2_data;
    word_t    wb_data, next_pc;
    logic     valid, reg_we;

    assign valid  = ~halted;
    assign reg_we = dec.ctrl.reg_we && valid;   // nothing written once halted

    pc_unit #(
        .reset_pc(reset_pc)
    ) i_pc_unit (
        .clk    (clk),
        .reset  (reset),
        .next_pc(next_pc),
        .ebreak (dec.ctrl.ebreak),
        .pc     (pc),
        .halted (halted)
    );

    inst_decoder i_inst_decoder (
        .inst(inst),
        .dec (dec)
    );

    reg_file i_reg_file (
        .clk   (clk),
        .reset (reset),
        .we    (reg_we),
        .waddr (dec.rd),
        .wdata (wb_data),
        .raddr1(dec.rs1),
        .raddr2(dec.rs2),
        .rdata1(rs1_data),
        .rdata2(rs2_data)
    );

    exec_unit i_exec_unit (
        .ctrl    (dec.ctrl),
        .imm     (dec.imm),
        .pc      (pc),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb_data (wb_data),
        .next_pc (next_pc)
    );

    // one retire per running cycle
    assign retire.valid = valid;
    assign retire.pc    = pc;
    assign retire.rd    = dec.rd;
    assign retire.we    = reg_we;
    assign retire.wdata = wb_data;

endmodule

// ==== dv/tb_clock.sv ====
// *************************************************************************
// testbench clock and reset
// *************************************************************************

module tb_clock #(
    parameter int period       = 100,
    parameter int reset_cycles = 10
) (
    input  logic reset_req,     // restarts the reset count
    output logic clk,
    output logic reset
);

    int count = reset_cycles;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset_req) begin
            count <= reset_cycles;
        end else if (count != 0) begin
            count <= count - 1;
        end
    end

    assign reset = (count != 0);

endmodule

// ==== dv/rv_core_tb.sv ====
// *************************************************************************
// rv32i core testbench
// *************************************************************************

module rv_core_tb;
    import rv_pkg::*;

    localparam int    period       = 100;
    localparam int    reset_cycles = 10;
    localparam int    mem_words    = 128;
    localparam int    n_tests      = 4;
    localparam word_t reset_pc     = 32'h8000_0000;
    localparam word_t ebreak_inst  = 32'h0010_0073;
    // each program fits in memory, so this bounds every test
    localparam int    limit = 2 * n_tests * (mem_words + reset_cycles + 8) * period;

    logic    clk, reset, reset_req;
    logic    halted;
    word_t   inst, pc, idx;
    retire_t retire;

    word_t   imem [mem_words];
    int      n_words;
    word_t   rng_state = 32'd4291;
    string   test_name;
    int      errors, tests_run, tests_failed;

    // architectural reference state
    word_t   model_regs [32];
    word_t   exp_pc;
    logic    exp_halted;

    tb_clock #(
        .period      (period),
        .reset_cycles(reset_cycles)
    ) i_tb_clock (
        .reset_req(reset_req),
        .clk      (clk),
        .reset    (reset)
    );

    rv_core #(
        .reset_pc(reset_pc)
    ) i_rv_core (
        .clk   (clk),
        .reset (reset),
        .inst  (inst),
        .pc    (pc),
        .halted(halted),
        .retire(retire)
    );

    assign idx  = (pc - reset_pc) >> 2;
    assign inst = (idx < mem_words) ? imem[idx] : ebreak_inst;  // outside reads as ebreak

    function automatic word_t xorshift();
        word_t x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t i_type(input logic [6:0] op, input logic [2:0] f3,
                                     input reg_addr_t rd, rs1, input word_t imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic word_t u_type(input logic [6:0] op, input reg_addr_t rd, input word_t imm);
        return {imm[31:12], rd, op};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input reg_addr_t rs1, rs2,
                                     input word_t off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic word_t j_type(input reg_addr_t rd, input word_t off);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic void clear_mem();
        foreach (imem[i]) begin
            imem[i] = ebreak_inst;
        end
        n_words = 0;
    endfunction

    function automatic void emit(input word_t w);
        imem[n_words] = w;
        n_words++;
    endfunction

    // upper part rounded so the addi sign extension lands on v
    function automatic void load_reg(input reg_addr_t r, input word_t v);
        emit(u_type(op_lui, r, v + 32'h800));
        emit(i_type(op_imm, 3'b000, r, r, v));
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a, b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t a, b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // expected effect of one instruction at pc at
    function automatic void predict(input word_t ins, input word_t at, output logic wr,
                                    output word_t wd, output word_t npc);
        word_t a, b, imm_i, imm_b;
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        wr    = (ins[11:7] != 5'd0);
        wd    = at + 32'd4;     // link value
        npc   = at + 32'd4;
        case (ins[6:0])
            op_reg:   wd = alu_ref(ins[14:12], ins[30], a, b);
            op_imm:   wd = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
            op_lui:   wd = {ins[31:12], 12'h000};
            op_auipc: wd = at + {ins[31:12], 12'h000};
            op_jal:   npc = at + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            op_jalr:  npc = (a + imm_i) & ~32'd1;
            op_branch: begin
                wr = 1'b0;
                if (branch_ref(ins[14:12], a, b)) npc = at + imm_b;
            end
            default:  wr = 1'b0;    // ebreak
        endcase
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        assert (act == exp) else begin
            errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin : check_retire
        logic  wr;
        word_t wd, npc;
        if (reset) begin
            foreach (model_regs[i]) begin
                model_regs[i] = '0;
            end
            exp_pc     = reset_pc;
            exp_halted = 1'b0;
        end else if (exp_halted) begin
            assert (halted && !retire.valid && pc == exp_pc) else begin
                errors++;
                $display("%s: core kept running or pc moved after ebreak", test_name);
            end
        end else begin
            assert (retire.valid && !halted) else begin
                errors++;
                $display("%s: core stopped without reaching an ebreak", test_name);
            end
            check_word("pc", exp_pc, retire.pc);
            predict(inst, exp_pc, wr, wd, npc);
            check_word("we", {31'b0, wr}, {31'b0, retire.we});
            if (wr) begin
                check_word("rd", {27'b0, inst[11:7]}, {27'b0, retire.rd});
                check_word("wdata", wd, retire.wdata);
                model_regs[inst[11:7]] = wd;
            end
            if (inst == ebreak_inst) begin
                exp_halted = 1'b1;  // pc stays on the ebreak
            end else begin
                exp_pc = npc;
            end
        end
    end

    // once halted the core stays halted with pc frozen until reset
    assert property (@(negedge clk) disable iff (reset) halted |=> halted && $stable(pc))
        else begin
            errors++;
            $display("%s: core left the halted state or pc moved while halted", test_name);
        end

    task automatic run_test(input string name);
        int errors_before;
        errors_before = errors;
        test_name     = name;
        @(posedge clk);
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        wait (reset);
        wait (!reset);
        @(negedge clk);
        assert (pc == reset_pc && !halted && retire.valid && retire.pc == reset_pc) else begin
            errors++;
            $display("%s: core did not start running at reset_pc", name);
        end
        wait (halted);
        repeat (3) @(negedge clk);  // a few idle cycles after the halt
        tests_run++;
        if (errors != errors_before) tests_failed++;
        $display("%s: %s", name, (errors == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        reset_req    = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        clear_mem();
        for (int k = 0; k < 3; k++) begin
            load_reg(5'd1, xorshift());
            load_reg(5'd2, xorshift());
            for (int f = 0; f < 8; f++) begin
                emit(r_type(7'b0000000, f[2:0], 5'd3, 5'd1, 5'd2));
            end
            emit(r_type(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd2));    // sub
            emit(r_type(7'b0100000, 3'b101, 5'd5, 5'd1, 5'd2));    // sra
            for (int f = 0; f < 8; f++) begin
                if (f == 1 || f == 5) begin
                    emit(i_type(op_imm, f[2:0], 5'd6, 5'd1, xorshift() & 32'h1f));
                end else begin
                    emit(i_type(op_imm, f[2:0], 5'd6, 5'd1, xorshift()));
                end
            end
            emit(i_type(op_imm, 3'b101, 5'd7, 5'd1, 32'h400 | (xorshift() & 32'h1f)));
        end
        run_test("alu");

        clear_mem();
        load_reg(5'd1, xorshift());
        emit(i_type(op_imm, 3'b000, 5'd0, 5'd1, xorshift()));  // result dropped
        emit(u_type(op_lui, 5'd0, xorshift()));
        emit(r_type(7'b0000000, 3'b000, 5'd5, 5'd0, 5'd1));
        emit(u_type(op_auipc, 5'd6, xorshift()));
        run_test("x0_auipc");

        clear_mem();
        load_reg(5'd1, xorshift());
        load_reg(5'd2, xorshift());
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                emit(b_type(f[2:0], 5'd1, 5'd2, 32'd8));
                emit(i_type(op_imm, 3'b000, 5'd7, 5'd7, 32'd1));
                emit(b_type(f[2:0], 5'd2, 5'd1, 32'd8));
                emit(i_type(op_imm, 3'b000, 5'd7, 5'd7, 32'd1));
                emit(b_type(f[2:0], 5'd1, 5'd1, 32'd8));
                emit(i_type(op_imm, 3'b000, 5'd7, 5'd7, 32'd1));
            end
        end
        run_test("branch");

        clear_mem();
        emit(j_type(5'd8, 32'd8));
        emit(i_type(op_imm, 3'b000, 5'd7, 5'd7, 32'd1));  // skipped
        emit(u_type(op_auipc, 5'd10, 32'd0));
        emit(i_type(op_jalr, 3'b000, 5'd9, 5'd10, 32'd13));  // odd target
        emit(i_type(op_imm, 3'b000, 5'd7, 5'd7, 32'd1));
        emit(i_type(op_imm, 3'b000, 5'd11, 5'd9, 32'd3));
        run_test("jump");

        $display("tests: %0d run, %0d failed, %0d failed checks", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(limit);
        $display("timeout: the tests did not finish within %0d time units", limit);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== project.f ====
source/rv_pkg.sv
source/pc_unit.sv
source/inst_decoder.sv
source/reg_file.sv
source/exec_unit.sv
source/rv_core.sv
dv/tb_clock.sv
dv/rv_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the rv_core testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module rv_core_tb -Mdir obj_dir -f project.f \
    && ./obj_dir/Vrv_core_tb > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0
